/* hdl/dwc_pkg.sv */
// Shared constants, channel structs and address helpers that every upsizer RTL module imports
package dwc_pkg;

  // Bus widths of the narrow master side and the wide slave side
  localparam int unsigned NarrowDataWidth = 32;
  localparam int unsigned WideDataWidth   = 64;
  localparam int unsigned NarrowStrbWidth = NarrowDataWidth / 8;
  localparam int unsigned WideStrbWidth   = WideDataWidth / 8;
  // log2 of the wide beat size in bytes
  localparam int unsigned WideMaxSize     = 3;
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned IdWidth         = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [7:0]           len_t;
  typedef logic [2:0]           size_t;
  typedef logic [1:0]           burst_t;
  typedef logic [1:0]           resp_t;

  // Burst type encodings
  localparam burst_t BurstFixed = 2'b00;
  localparam burst_t BurstIncr  = 2'b01;
  localparam burst_t BurstWrap  = 2'b10;

  // Response encodings
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlverr = 2'b10;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    size_t      size;
    burst_t     burst;
    logic [3:0] cache;
  } aw_chan_t;

  typedef struct packed {
    logic [NarrowDataWidth-1:0] data;
    logic [NarrowStrbWidth-1:0] strb;
    logic                       last;
  } narrow_w_t;

  typedef struct packed {
    logic [WideDataWidth-1:0] data;
    logic [WideStrbWidth-1:0] strb;
    logic                     last;
  } wide_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // How a write burst travels through the converter
  typedef enum logic [1:0] {
    MODE_PASS,
    MODE_UPSIZE,
    MODE_ERROR
  } wr_mode_e;

  // Decoded burst as seen by the W packer and the output port
  typedef struct packed {
    aw_chan_t aw;
    size_t    orig_size;
    len_t     orig_len;
    addr_t    start_addr;
    wr_mode_e mode;
  } wr_cmd_t;

  // Clear the address bits below the given transfer size
  function automatic addr_t aligned_addr(input addr_t addr, input size_t size);
    return (addr >> size) << size;
  endfunction

  // Cache bit 1 marks a burst that may be merged or split
  function automatic logic modifiable(input logic [3:0] cache);
    return cache[1];
  endfunction

endpackage

/* hdl/aw_decoder.sv */
// Narrow AW acceptance stage; classifies each burst and issues the wide write command
`timescale 1ns/1ps

module aw_decoder (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  dwc_pkg::aw_chan_t slv_aw_i,
  input  logic              slv_aw_valid_i,
  output logic              slv_aw_ready_o,
  output dwc_pkg::wr_cmd_t  cmd_o,
  output logic              cmd_valid_o,
  input  logic              burst_done_i
);

  import dwc_pkg::*;

  // INIT keeps AW ready low for the first cycle out of reset
  typedef enum logic [1:0] {
    DEC_INIT,
    DEC_IDLE,
    DEC_BUSY
  } dec_state_e;

  dec_state_e state_q, state_d;
  wr_cmd_t    cmd_q, cmd_d;
  logic       cmd_valid_q;
  logic       aw_fire;
  logic       multi_beat;
  addr_t      last_beat_addr;
  addr_t      wide_start;
  addr_t      wide_end;
  addr_t      wide_span;

  assign slv_aw_ready_o = (state_q == DEC_IDLE);
  assign aw_fire        = slv_aw_valid_i && slv_aw_ready_o;
  assign multi_beat     = (slv_aw_i.len != '0);

  // Address of the final narrow beat of an INCR burst
  assign last_beat_addr = aligned_addr(slv_aw_i.addr, slv_aw_i.size) +
                          (addr_t'(slv_aw_i.len) << slv_aw_i.size);
  assign wide_start     = aligned_addr(slv_aw_i.addr, size_t'(WideMaxSize));
  assign wide_end       = aligned_addr(last_beat_addr, size_t'(WideMaxSize));
  assign wide_span      = wide_end - wide_start;

  always_comb begin
    cmd_d            = '0;
    cmd_d.aw         = slv_aw_i;
    cmd_d.orig_size  = slv_aw_i.size;
    cmd_d.orig_len   = slv_aw_i.len;
    cmd_d.start_addr = slv_aw_i.addr;
    cmd_d.mode       = MODE_PASS;
    if (slv_aw_i.burst == BurstIncr && modifiable(slv_aw_i.cache) && multi_beat) begin
      cmd_d.mode    = MODE_UPSIZE;
      cmd_d.aw.len  = len_t'(wide_span >> WideMaxSize);
      cmd_d.aw.size = size_t'(WideMaxSize);
    end else if ((slv_aw_i.burst == BurstWrap || slv_aw_i.burst == BurstFixed) &&
                 multi_beat) begin
      // Multi-beat WRAP and FIXED cannot be converted
      cmd_d.mode = MODE_ERROR;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      DEC_INIT: state_d = DEC_IDLE;
      DEC_IDLE: if (aw_fire) state_d = DEC_BUSY;
      DEC_BUSY: if (burst_done_i) state_d = DEC_IDLE;
      default:  state_d = DEC_INIT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= DEC_INIT;
      cmd_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      cmd_valid_q <= aw_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      cmd_q <= cmd_d;
    end
  end

  assign cmd_o       = cmd_q;
  assign cmd_valid_o = cmd_valid_q;

endmodule

/* hdl/w_packer.sv */
// W lane steering stage; merges narrow write beats into wide beats for the output port
`timescale 1ns/1ps

module w_packer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dwc_pkg::wr_cmd_t   cmd_i,
  input  logic               cmd_valid_i,
  input  logic               aw_done_i,
  input  dwc_pkg::narrow_w_t slv_w_i,
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  output dwc_pkg::wide_w_t   wide_w_o,
  output logic               wide_valid_o,
  input  logic               wide_ready_i,
  output logic               burst_done_o
);

  import dwc_pkg::*;

  // Burst tracking
  addr_t   addr_q;
  len_t    count_q;
  size_t   size_q;
  logic    upsize_q;
  logic    active_q;
  logic    new_word_q;

  // Wide beat register
  wide_w_t wide_q, wide_d;
  logic    wide_valid_q;

  logic       w_fire;
  logic       wide_fire;
  logic       last_beat;
  logic       word_end;
  logic       release_beat;
  addr_t      next_addr;
  logic [2:0] wide_off;
  logic [1:0] narrow_off;
  logic [7:0] beat_bytes;

  assign slv_w_ready_o = aw_done_i && active_q && (!wide_valid_q || wide_ready_i);
  assign w_fire        = slv_w_valid_i && slv_w_ready_o;
  assign wide_fire     = wide_valid_q && wide_ready_i;

  assign wide_off   = addr_q[WideMaxSize-1:0];
  assign narrow_off = addr_q[1:0];
  assign beat_bytes = 8'(1) << size_q;

  assign next_addr = aligned_addr(addr_q, size_q) + (addr_t'(1) << size_q);
  assign last_beat = (count_q == '0);
  assign word_end  = aligned_addr(next_addr, size_t'(WideMaxSize)) !=
                     aligned_addr(addr_q, size_t'(WideMaxSize));
  // Pass and error bursts emit one wide beat per narrow beat
  assign release_beat = !upsize_q || last_beat || word_end;

  always_comb begin
    int src;
    wide_d = wide_q;
    if (new_word_q) begin
      wide_d.strb = '0;
    end
    for (int b = 0; b < WideStrbWidth; b++) begin
      src = b - int'(wide_off) + int'(narrow_off);
      if ((b >= int'(wide_off)) && (b - int'(wide_off) < int'(beat_bytes)) &&
          (src < NarrowStrbWidth)) begin
        wide_d.data[8*b +: 8] = slv_w_i.data[8*src +: 8];
        wide_d.strb[b]        = slv_w_i.strb[src];
      end
    end
    wide_d.last = last_beat;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      upsize_q     <= 1'b0;
      active_q     <= 1'b0;
      new_word_q   <= 1'b1;
      wide_valid_q <= 1'b0;
    end else begin
      if (cmd_valid_i) begin
        upsize_q   <= (cmd_i.mode == MODE_UPSIZE);
        active_q   <= 1'b1;
        new_word_q <= 1'b1;
      end
      if (wide_fire) begin
        wide_valid_q <= 1'b0;
      end
      if (w_fire) begin
        new_word_q <= release_beat;
        if (release_beat) begin
          wide_valid_q <= 1'b1;
        end
        if (last_beat) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      addr_q  <= cmd_i.start_addr;
      count_q <= cmd_i.orig_len;
      size_q  <= cmd_i.orig_size;
    end else if (w_fire) begin
      addr_q  <= next_addr;
      count_q <= count_q - 8'd1;
    end
    if (w_fire) begin
      wide_q <= wide_d;
    end
  end

  assign wide_w_o     = wide_q;
  assign wide_valid_o = wide_valid_q;
  // Burst ends when its last wide beat leaves
  assign burst_done_o = wide_fire && wide_q.last;

endmodule

/* hdl/mst_write_port.sv */
// Wide output stage; issues AW, routes W to the slave or error sink, and returns B
`timescale 1ns/1ps

module mst_write_port (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  dwc_pkg::wr_cmd_t  cmd_i,
  input  logic              cmd_valid_i,
  output logic              aw_done_o,
  input  dwc_pkg::wide_w_t  wide_w_i,
  input  logic              wide_valid_i,
  output logic              wide_ready_o,
  output dwc_pkg::aw_chan_t mst_aw_o,
  output logic              mst_aw_valid_o,
  input  logic              mst_aw_ready_i,
  output dwc_pkg::wide_w_t  mst_w_o,
  output logic              mst_w_valid_o,
  input  logic              mst_w_ready_i,
  input  dwc_pkg::b_chan_t  mst_b_i,
  input  logic              mst_b_valid_i,
  output logic              mst_b_ready_o,
  output dwc_pkg::b_chan_t  slv_b_o,
  output logic              slv_b_valid_o,
  input  logic              slv_b_ready_i
);

  import dwc_pkg::*;

  aw_chan_t aw_q;
  logic     aw_valid_q;
  logic     aw_done_q;
  logic     err_q;
  id_t      err_id_q;
  logic     b_err_q;
  logic     aw_fire;
  logic     wide_last_fire;

  assign aw_fire        = aw_valid_q && mst_aw_ready_i;
  assign wide_last_fire = wide_valid_i && wide_ready_o && wide_w_i.last;
  assign aw_done_o      = aw_done_q || aw_fire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_valid_q <= 1'b0;
      aw_done_q  <= 1'b0;
      err_q      <= 1'b0;
      b_err_q    <= 1'b0;
    end else begin
      if (cmd_valid_i) begin
        if (cmd_i.mode == MODE_ERROR) begin
          // Nothing goes downstream and the sink drains W
          err_q     <= 1'b1;
          aw_done_q <= 1'b1;
        end else begin
          aw_valid_q <= 1'b1;
        end
      end
      if (aw_fire) begin
        aw_valid_q <= 1'b0;
        aw_done_q  <= 1'b1;
      end
      if (wide_last_fire) begin
        aw_done_q <= 1'b0;
        err_q     <= 1'b0;
        b_err_q   <= err_q;
      end
      if (b_err_q && slv_b_ready_i) begin
        b_err_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      aw_q     <= cmd_i.aw;
      err_id_q <= cmd_i.aw.id;
    end
  end

  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_valid_q;

  // Error bursts are swallowed here
  assign mst_w_o       = wide_w_i;
  assign mst_w_valid_o = wide_valid_i && !err_q;
  assign wide_ready_o  = err_q ? 1'b1 : mst_w_ready_i;

  // Pending SLVERR takes the B channel ahead of the slave
  assign slv_b_o       = b_err_q ? b_chan_t'{id: err_id_q, resp: RespSlverr} : mst_b_i;
  assign slv_b_valid_o = b_err_q || mst_b_valid_i;
  assign mst_b_ready_o = !b_err_q && slv_b_ready_i;

endmodule

/* hdl/dw_upsizer_top.sv */
// Write-path upsizer top; joins a 32-bit narrow master to a 64-bit wide slave
`timescale 1ns/1ps

module dw_upsizer_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Narrow side from the master
  input  dwc_pkg::aw_chan_t  slv_aw_i,
  input  logic               slv_aw_valid_i,
  output logic               slv_aw_ready_o,
  input  dwc_pkg::narrow_w_t slv_w_i,
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  output dwc_pkg::b_chan_t   slv_b_o,
  output logic               slv_b_valid_o,
  input  logic               slv_b_ready_i,
  // Wide side towards the slave
  output dwc_pkg::aw_chan_t  mst_aw_o,
  output logic               mst_aw_valid_o,
  input  logic               mst_aw_ready_i,
  output dwc_pkg::wide_w_t   mst_w_o,
  output logic               mst_w_valid_o,
  input  logic               mst_w_ready_i,
  input  dwc_pkg::b_chan_t   mst_b_i,
  input  logic               mst_b_valid_i,
  output logic               mst_b_ready_o
);

  import dwc_pkg::*;

  wr_cmd_t cmd;
  logic    cmd_valid;
  logic    aw_done;
  logic    burst_done;
  wide_w_t wide_w;
  logic    wide_valid;
  logic    wide_ready;

  aw_decoder i_aw_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .cmd_o          (cmd),
    .cmd_valid_o    (cmd_valid),
    .burst_done_i   (burst_done)
  );

  w_packer i_w_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd),
    .cmd_valid_i   (cmd_valid),
    .aw_done_i     (aw_done),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .wide_w_o      (wide_w),
    .wide_valid_o  (wide_valid),
    .wide_ready_i  (wide_ready),
    .burst_done_o  (burst_done)
  );

  mst_write_port i_mst_write_port (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_i          (cmd),
    .cmd_valid_i    (cmd_valid),
    .aw_done_o      (aw_done),
    .wide_w_i       (wide_w),
    .wide_valid_i   (wide_valid),
    .wide_ready_o   (wide_ready),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_w_o        (mst_w_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_b_i        (mst_b_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_ready_o  (mst_b_ready_o),
    .slv_b_o        (slv_b_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i)
  );

endmodule

/* verification/upsizer_tasks.svh */
// Directed upsizer tests included into the testbench top; each drives bursts and checks results

task automatic report_mismatch(input string msg);
  errors++;
  $display("FAIL %0t: %s", $time, msg);
endtask

task automatic abort_on_timeout(input string what);
  $display("Timeout at %0t while waiting for %s", $time, what);
  $display("SOME TESTS FAILED");
  $finish;
endtask

function automatic aw_chan_t make_aw(input id_t id, input addr_t addr, input len_t len,
                                     input burst_t burst, input logic [3:0] cache);
  return '{id: id, addr: addr, len: len, size: 3'd2, burst: burst, cache: cache};
endfunction

// Expected wide beats from the beat address and lane rules
task automatic build_expected(input aw_chan_t aw, input narrow_w_t beats[$],
                              input logic upsize, output wide_w_t exp_q[$]);
  addr_t       a;
  int          nbytes;
  int          lane;
  int          nlane;
  logic [63:0] data;
  logic [7:0]  strb;
  exp_q  = {};
  nbytes = 1 << aw.size;
  data   = '0;
  strb   = '0;
  for (int i = 0; i <= int'(aw.len); i++) begin
    a     = ((aw.addr >> aw.size) << aw.size) + (addr_t'(i) << aw.size);
    lane  = int'(a[2:0]);
    nlane = int'(a[1:0]);
    for (int k = 0; k < nbytes; k++) begin
      data[8*(lane+k) +: 8] = beats[i].data[8*(nlane+k) +: 8];
      strb[lane+k]          = beats[i].strb[nlane+k];
    end
    if (!upsize || i == int'(aw.len) || ((a + addr_t'(nbytes)) >> 3) != (a >> 3)) begin
      exp_q.push_back(wide_w_t'{data: data, strb: strb, last: (i == int'(aw.len))});
      data = '0;
      strb = '0;
    end
  end
endtask

task automatic drive_and_check(input aw_chan_t aw);
  narrow_w_t   beats[$];
  wide_w_t     exp_q[$];
  aw_chan_t    exp_aw;
  logic        upsize;
  logic        err;
  logic [63:0] mask;
  addr_t       last_addr;
  int          cnt;
  tests++;
  aw_seen = {};
  w_seen  = {};
  b_seen  = {};
  upsize  = (aw.burst == BurstIncr) && aw.cache[1] && (aw.len != 0);
  err     = (aw.burst != BurstIncr) && (aw.len != 0);
  for (int i = 0; i <= int'(aw.len); i++) begin
    data_state = xorshift32(data_state);
    beats.push_back(narrow_w_t'{data: data_state, strb: 4'hF, last: (i == int'(aw.len))});
  end
  @(posedge clk_i);
  slv_aw       <= aw;
  slv_aw_valid <= 1'b1;
  cnt = 0;
  @(posedge clk_i);
  while (!slv_aw_ready) begin
    cnt++;
    if (cnt > Timeout) abort_on_timeout("narrow AW ready");
    @(posedge clk_i);
  end
  slv_aw_valid <= 1'b0;
  foreach (beats[i]) begin
    slv_w       <= beats[i];
    slv_w_valid <= 1'b1;
    cnt = 0;
    @(posedge clk_i);
    while (!slv_w_ready) begin
      cnt++;
      if (cnt > Timeout) abort_on_timeout("narrow W ready");
      @(posedge clk_i);
    end
  end
  slv_w_valid <= 1'b0;
  cnt = 0;
  while (b_seen.size() == 0) begin
    cnt++;
    if (cnt > Timeout) abort_on_timeout("narrow B response");
    @(posedge clk_i);
  end
  build_expected(aw, beats, upsize, exp_q);
  exp_aw = aw;
  if (upsize) begin
    last_addr     = aw.addr + (addr_t'(aw.len) << aw.size);
    exp_aw.len    = len_t'(((last_addr & ~32'h7) - (aw.addr & ~32'h7)) >> 3);
    exp_aw.size   = 3'd3;
  end
  if (err) begin
    if (aw_seen.size() != 0) report_mismatch("error burst reached the wide AW");
    if (w_seen.size() != 0) report_mismatch("error burst reached the wide W");
  end else begin
    if (aw_seen.size() != 1) begin
      report_mismatch($sformatf("wide AW count %0d, expected 1", aw_seen.size()));
    end else if (aw_seen[0] !== exp_aw) begin
      report_mismatch($sformatf("wide AW %p, expected %p", aw_seen[0], exp_aw));
    end
    if (w_seen.size() != exp_q.size()) begin
      report_mismatch($sformatf("wide W count %0d, expected %0d", w_seen.size(), exp_q.size()));
    end else begin
      foreach (exp_q[i]) begin
        for (int b = 0; b < 8; b++) begin
          mask[8*b +: 8] = {8{exp_q[i].strb[b]}};
        end
        if (w_seen[i].strb !== exp_q[i].strb || w_seen[i].last !== exp_q[i].last ||
            (w_seen[i].data & mask) !== (exp_q[i].data & mask)) begin
          report_mismatch($sformatf("wide W %0d is %h/%h/%b, expected %h/%h/%b", i,
                                    w_seen[i].data, w_seen[i].strb, w_seen[i].last,
                                    exp_q[i].data, exp_q[i].strb, exp_q[i].last));
        end
      end
    end
  end
  if (b_seen[0].id !== aw.id || b_seen[0].resp !== (err ? RespSlverr : RespOkay)) begin
    report_mismatch($sformatf("B id %0d resp %0d for burst id %0d", b_seen[0].id,
                              b_seen[0].resp, aw.id));
  end
endtask

task automatic aligned_upsize();
  drive_and_check(make_aw(4'h1, 32'h100, 8'd3, BurstIncr, 4'h2));
  if (aw_seen.size() == 1 && (aw_seen[0].len !== 8'd1 || aw_seen[0].size !== 3'd3)) begin
    report_mismatch("aligned upsize did not give wide len 1 size 3");
  end
endtask

task automatic unaligned_upsize();
  drive_and_check(make_aw(4'h2, 32'h104, 8'd2, BurstIncr, 4'h2));
  if (w_seen.size() > 0 && w_seen[0].strb !== 8'hF0) begin
    report_mismatch($sformatf("first unaligned strobes %h, expected f0", w_seen[0].strb));
  end
endtask

task automatic pass_through();
  drive_and_check(make_aw(4'h3, 32'h100, 8'd3, BurstIncr, 4'h0));
endtask

task automatic error_burst();
  drive_and_check(make_aw(4'h5, 32'h100, 8'd3, BurstWrap, 4'h2));
endtask

task automatic single_wrap();
  drive_and_check(make_aw(4'h6, 32'h10C, 8'd0, BurstWrap, 4'h2));
endtask

task automatic back_pressure_series();
  addr_t a;
  len_t  l;
  bp_en <= 1'b1;
  for (int n = 0; n < 8; n++) begin
    data_state = xorshift32(data_state);
    a = 32'h200 + (data_state & 32'h3C);
    l = len_t'(1 + (data_state[15:8] % 7));
    drive_and_check(make_aw(id_t'(n), a, l, BurstIncr, 4'h3));
  end
  bp_en <= 1'b0;
endtask

/* verification/upsizer_tb.sv */
// Testbench top for the write upsizer; wide-slave model, clock, reset and final report
`timescale 1ns/1ps

module upsizer_tb;

  import dwc_pkg::*;

  localparam int unsigned Timeout = 200;
  localparam logic [31:0] Seed    = 32'h6a8f_d886;

  logic clk_i  = 1'b0;
  logic rst_ni = 1'b0;

  aw_chan_t  slv_aw       = '0;
  logic      slv_aw_valid = 1'b0;
  logic      slv_aw_ready;
  narrow_w_t slv_w        = '0;
  logic      slv_w_valid  = 1'b0;
  logic      slv_w_ready;
  b_chan_t   slv_b;
  logic      slv_b_valid;
  logic      slv_b_ready  = 1'b1;

  aw_chan_t mst_aw;
  logic     mst_aw_valid;
  logic     mst_aw_ready = 1'b1;
  wide_w_t  mst_w;
  logic     mst_w_valid;
  logic     mst_w_ready  = 1'b1;
  b_chan_t  mst_b        = '0;
  logic     mst_b_valid  = 1'b0;
  logic     mst_b_ready;

  // Slave model records and monitor queues
  aw_chan_t aw_seen[$];
  wide_w_t  w_seen[$];
  b_chan_t  b_seen[$];
  id_t      open_ids[$];
  id_t      b_ids[$];

  logic        bp_en      = 1'b0;
  logic [31:0] rdy_state  = Seed;
  logic [31:0] data_state = Seed;
  int          errors     = 0;
  int          tests      = 0;

  dw_upsizer_top dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_i        (slv_w),
    .slv_w_valid_i  (slv_w_valid),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_o        (slv_b),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_ready_i  (slv_b_ready),
    .mst_aw_o       (mst_aw),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o        (mst_w),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_i        (mst_b),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready)
  );

  initial begin
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random ready on the wide AW and W channels when back-pressure is on
  always @(posedge clk_i) begin
    if (bp_en) begin
      rdy_state = xorshift32(rdy_state);
      mst_aw_ready <= rdy_state[4];
      mst_w_ready  <= rdy_state[9] | rdy_state[17];
    end else begin
      mst_aw_ready <= 1'b1;
      mst_w_ready  <= 1'b1;
    end
  end

  // Wide slave model answering each burst with an OKAY that carries the AW id
  always @(posedge clk_i) begin
    if (mst_b_valid && mst_b_ready) begin
      void'(b_ids.pop_front());
    end
    if (mst_aw_valid && mst_aw_ready) begin
      aw_seen.push_back(mst_aw);
      open_ids.push_back(mst_aw.id);
    end
    if (mst_w_valid && mst_w_ready) begin
      w_seen.push_back(mst_w);
      if (mst_w.last) begin
        b_ids.push_back(open_ids.pop_front());
      end
    end
    mst_b_valid <= (b_ids.size() > 0);
    if (b_ids.size() > 0) begin
      mst_b <= '{id: b_ids[0], resp: RespOkay};
    end
  end

  // Narrow B monitor
  always @(posedge clk_i) begin
    if (slv_b_valid && slv_b_ready) begin
      b_seen.push_back(slv_b);
    end
  end

  `include "upsizer_tasks.svh"

  initial begin
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    aligned_upsize();
    unaligned_upsize();
    pass_through();
    error_burst();
    single_wrap();
    back_pressure_series();
    repeat (4) @(posedge clk_i);
    $display("Bursts run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
hdl/dwc_pkg.sv
hdl/aw_decoder.sv
hdl/w_packer.sv
hdl/mst_write_port.sv
hdl/dw_upsizer_top.sv
+incdir+verification
verification/upsizer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the upsizer testbench with Verilator; pass is decided by the printed result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module upsizer_tb -o upsizer_sim \
  && ./obj_dir/upsizer_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
